// File: or1k_decode_top.f
or1k_decode_pkg.sv
or1k_decode_class.sv
or1k_decode_imm.sv
or1k_decode_alu.sv
or1k_decode_illegal.sv
or1k_decode_top.sv
or1k_decode_asserts.sv
tb_or1k_decode.sv

// File: Makefile
# Verilator flow for the OR1K decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_or1k_decode
FILELIST  ?= or1k_decode_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: or1k_decode_cases.txt
// insn class immediate imm_sel rfd alu exc; class bits 31..12 load..rf_wb, bit 10 zext, 9:8 length
// alu digits: opc_alu, secondary, sub, carry; exc digits: illegal, syscall, trap
8c640010 80001400 00000010 1 03 0000 000 // lbz
9864fffc 80001100 fffffffc 1 03 c300 000 // lhs
84640100 80001600 00000100 1 03 0000 000 // lwz
d7e42ff8 40000600 fffffff8 1 1f 8300 000 // sw with negative split immediate
d8043005 40000000 00000005 1 00 5000 000 // sb
dc243802 40000500 00000802 1 01 2000 000 // sh
6c640020 a0001600 00000020 1 03 0000 000 // lwa
cc042804 60000600 00000004 1 00 4000 000 // swa
9c64ffff 00011600 ffffffff 1 03 f300 000 // addi
a8648001 00801200 00008001 1 03 4000 000 // ori
18601234 00041200 12340000 1 03 4000 000 // movhi
c2042803 00100200 00008003 1 10 3000 000 // mtspr
e0642800 00811200 00000000 0 03 0000 000 // add
00000100 11000200 00000000 0 00 0000 000 // j
10000040 13000200 00000000 0 00 0100 000 // bf
0ffffffc 13000600 00000000 0 1f c300 000 // bnf
04000010 15001600 00000000 0 09 0000 000 // jal
48002800 0d001200 00000000 0 09 0000 000 // jalr through r5
44002800 09000600 00000000 0 00 0000 000 // jr
ac6400c5 00801600 000000c5 1 03 5300 000 // xori
e0642802 00811200 00000000 0 03 2010 000 // sub
e5442800 00400600 00000000 0 0a 0a10 000 // sfgts
bc040010 00400600 00000010 1 00 0010 000 // sfeqi
e0642801 00811200 00000000 0 03 1000 100 // addc
e0642809 00805200 00000000 0 03 9000 100 // div
e06428c8 00803200 00000000 0 03 8300 100 // ror
e0642888 00803200 00000000 0 03 8200 000 // sra
e0642806 00809200 00000000 0 03 6000 000 // mul
fc640000 00001600 00000000 0 03 0000 100 // unknown opcode
48004800 0d001200 00000000 0 09 0000 100 // jalr through the link register
20000001 00000200 00000000 0 00 1000 010 // sys
21000002 00000200 00000000 0 08 2000 001 // trap
22000000 00020200 00000000 0 10 0000 000 // msync
b4640011 00201600 00000011 1 03 1000 000 // mfspr
24000000 00080600 00000000 0 00 0000 000 // rfe
00000000 ffffffff 00000000 0 00 0000 000 // end marker

// File: tb_or1k_decode.sv
//=============================
// Testbench for the registered decode stage.
// Reads cases from or1k_decode_cases.txt,
// runs them with random gaps, then back to back
//=============================
`timescale 1ns/10ps

module tb_or1k_decode import or1k_decode_pkg::*; ();

   localparam int words_per_case = 7;
   localparam int max_cases      = 48;
   localparam int timeout_cycles = 10;

   logic                     clk, reset_i, insn_valid_i;
   logic [insn_width-1:0]    insn_i;
   logic                     dec_valid_o;
   logic                     op_load_o, op_store_o, op_atomic_o, op_jbr_o, op_jr_o;
   logic                     op_jal_o, op_brcond_o, op_branch_o, op_alu_o, op_setflag_o;
   logic                     op_mfspr_o, op_mtspr_o, op_rfe_o, op_movhi_o, op_msync_o;
   logic                     op_add_o, op_mul_o, op_div_o, op_shift_o, rf_wb_o;
   logic [1:0]               lsu_length_o;
   logic                     lsu_zext_o;
   logic [15:0]              imm16_o;
   logic [insn_width-1:0]    immediate_o;
   logic                     immediate_sel_o;
   logic [9:0]               immjbr_upper_o;
   logic [rf_addr_width-1:0] rfd_adr_o, rfa_adr_o, rfb_adr_o;
   logic [alu_opc_width-1:0] opc_alu_o, opc_alu_secondary_o;
   logic                     adder_do_sub_o, adder_do_carry_o;
   logic                     except_illegal_o, except_syscall_o, except_trap_o;

   logic [31:0] case_mem [0:max_cases*words_per_case-1];
   logic [31:0] rng;
   int          errors, tests, passed, num_cases;

   or1k_decode_top dut0 (.*);

   initial clk = 1'b0;
   always #50 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] state);
      logic [31:0] s;
      s = state;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // Same bit order as the class column of the cases file
   function automatic logic [31:0] class_bits();
      return {op_load_o, op_store_o, op_atomic_o, op_jbr_o, op_jr_o, op_jal_o,
              op_brcond_o, op_branch_o, op_alu_o, op_setflag_o, op_mfspr_o, op_mtspr_o,
              op_rfe_o, op_movhi_o, op_msync_o, op_add_o, op_mul_o, op_div_o,
              op_shift_o, rf_wb_o, 1'b0, lsu_zext_o, lsu_length_o, 8'h00};
   endfunction

   function automatic logic [15:0] alu_bits();
      return {opc_alu_o, opc_alu_secondary_o, 3'b000, adder_do_sub_o,
              3'b000, adder_do_carry_o};
   endfunction

   function automatic logic [11:0] exc_bits();
      return {3'b000, except_illegal_o, 3'b000, except_syscall_o, 3'b000, except_trap_o};
   endfunction

   task automatic check_case(input int idx, output int bad);
      int          base;
      logic [31:0] insn;
      logic [15:0] exp_imm16;
      base = idx * words_per_case;
      insn = case_mem[base];
      bad  = 0;
      if (class_bits() !== case_mem[base+1]) begin
         $display("FAIL %0t: case %0d class %h, expected %h", $time, idx, class_bits(),
                  case_mem[base+1]);
         bad++;
      end
      if (immediate_sel_o !== case_mem[base+3][0]) begin
         $display("FAIL %0t: case %0d immediate_sel %b, expected %b", $time, idx,
                  immediate_sel_o, case_mem[base+3][0]);
         bad++;
      end
      // Immediate only means something when it is selected
      if (case_mem[base+3][0] && (immediate_o !== case_mem[base+2])) begin
         $display("FAIL %0t: case %0d immediate %h, expected %h", $time, idx,
                  immediate_o, case_mem[base+2]);
         bad++;
      end
      // Low half of an extended immediate, high half for movhi,
      // the raw field when nothing is selected
      if (!case_mem[base+3][0]) begin
         exp_imm16 = insn[15:0];
      end else if (case_mem[base+1][18]) begin
         exp_imm16 = case_mem[base+2][31:16];
      end else begin
         exp_imm16 = case_mem[base+2][15:0];
      end
      if (imm16_o !== exp_imm16) begin
         $display("FAIL %0t: case %0d imm16 %h, expected %h", $time, idx, imm16_o,
                  exp_imm16);
         bad++;
      end
      if (rfd_adr_o !== case_mem[base+4][rf_addr_width-1:0]) begin
         $display("FAIL %0t: case %0d rfd %0d, expected %0d", $time, idx, rfd_adr_o,
                  case_mem[base+4][rf_addr_width-1:0]);
         bad++;
      end
      // Source registers and jump target bits are plain fields of the word
      if ((rfa_adr_o !== insn[20:16]) || (rfb_adr_o !== insn[15:11])) begin
         $display("FAIL %0t: case %0d rfa %0d rfb %0d, expected %0d %0d", $time, idx,
                  rfa_adr_o, rfb_adr_o, insn[20:16], insn[15:11]);
         bad++;
      end
      if (immjbr_upper_o !== insn[25:16]) begin
         $display("FAIL %0t: case %0d immjbr_upper %h, expected %h", $time, idx,
                  immjbr_upper_o, insn[25:16]);
         bad++;
      end
      if (alu_bits() !== case_mem[base+5][15:0]) begin
         $display("FAIL %0t: case %0d alu controls %h, expected %h", $time, idx,
                  alu_bits(), case_mem[base+5][15:0]);
         bad++;
      end
      if (exc_bits() !== case_mem[base+6][11:0]) begin
         $display("FAIL %0t: case %0d exceptions %h, expected %h", $time, idx,
                  exc_bits(), case_mem[base+6][11:0]);
         bad++;
      end
   endtask

   // Cycles are counted from the strobe edge
   task automatic wait_decode(output int cycles);
      cycles = 0;
      do begin
         @(posedge clk);
         #5;
         insn_valid_i = 1'b0;
         cycles++;
      end while (!dec_valid_o && (cycles < timeout_cycles));
   endtask

   task automatic run_case(input int idx, input int idle);
      int cycles;
      int bad;
      int n;
      int k;
      insn_i       = case_mem[idx*words_per_case];
      insn_valid_i = 1'b1;
      wait_decode(cycles);
      tests++;
      if (!dec_valid_o) begin
         $display("Timeout: case %0d gave no decode within %0d cycles", idx, timeout_cycles);
         errors++;
      end else begin
         bad = 0;
         if (cycles != 1) begin
            $display("FAIL %0t: case %0d decoded after %0d cycles, expected 1", $time, idx,
                     cycles);
            bad++;
         end
         check_case(idx, n);
         bad += n;
         // Outputs hold while no strobe arrives
         for (k = 0; k < idle; k++) begin
            @(posedge clk);
            #5;
            if (dec_valid_o !== 1'b0) begin
               $display("FAIL %0t: case %0d dec_valid high on an idle cycle", $time, idx);
               bad++;
            end
            check_case(idx, n);
            bad += n;
         end
         errors += bad;
         if (bad == 0) begin
            passed++;
            $display("case %0d insn %h idle %0d: ok", idx, insn_i, idle);
         end else begin
            $display("case %0d insn %h idle %0d: failed", idx, insn_i, idle);
         end
      end
   endtask

   task automatic check_reset_state();
      int bad;
      int k;
      bad = 0;
      tests++;
      for (k = 0; k < 4; k++) begin
         if (dec_valid_o || ((class_bits() & 32'hfffff000) != 0) || immediate_sel_o ||
             (exc_bits() != 0)) begin
            $display("FAIL %0t: outputs not cleared after reset", $time);
            bad++;
         end
         @(posedge clk);
         #5;
      end
      errors += bad;
      if (bad == 0) begin
         passed++;
         $display("reset: ok");
      end else begin
         $display("reset: failed");
      end
   endtask

   initial begin
      int idle;
      reset_i      = 1'b1;
      insn_valid_i = 1'b0;
      insn_i       = '0;
      errors       = 0;
      tests        = 0;
      passed       = 0;
      rng          = 32'hebda;
      $readmemh("or1k_decode_cases.txt", case_mem);
      num_cases = 0;
      while ((num_cases < max_cases) &&
             (case_mem[num_cases*words_per_case+1] !== 32'hffffffff)) begin
         num_cases++;
      end
      if (num_cases == 0) begin
         $display("No cases could be read from or1k_decode_cases.txt");
         errors++;
      end
      repeat (2) @(posedge clk);
      #5;
      reset_i = 1'b0;
      check_reset_state();
      for (int i = 0; i < num_cases; i++) begin
         rng  = xorshift32(rng);
         idle = int'(rng[1:0]);
         run_case(i, idle);
      end
      // Same cases again with strobes on consecutive cycles
      for (int i = 0; i < num_cases; i++) begin
         run_case(i, 0);
      end
      $display("Tests: %0d run, %0d passed, %0d failed, %0d errors", tests, passed,
               tests - passed, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: or1k_decode_asserts.sv
//=============================
// Concurrent checks on the decode stage
// outputs, bound into the top level
//=============================
`timescale 1ns/10ps

module or1k_decode_asserts import or1k_decode_pkg::*; (
   input logic                  clk,
   input logic                  reset_i,
   input logic [insn_width-1:0] insn_i,
   input logic                  dec_valid_o,
   input logic op_load_o, op_store_o, op_mfspr_o, op_mtspr_o, op_rfe_o,
   input logic op_setflag_o, op_add_o, op_mul_o, op_div_o, op_shift_o,
   input logic op_movhi_o, op_msync_o, op_branch_o,
   input logic except_syscall_o, except_trap_o
);

   logic [12:0] excl_ops;

   assign excl_ops = {op_load_o, op_store_o, op_mfspr_o, op_mtspr_o, op_rfe_o,
                      op_setflag_o, op_add_o, op_mul_o, op_div_o, op_shift_o,
                      op_movhi_o, op_msync_o, op_branch_o};

   a_one_class: assert property (@(posedge clk) disable iff (reset_i)
      dec_valid_o |-> $onehot0(excl_ops))
      else $error("more than one exclusive operation class flagged");

   a_reset_clears_valid: assert property (@(posedge clk) reset_i |=> !dec_valid_o)
      else $error("dec_valid_o high in the cycle after reset");

   // A fresh syscall or trap comes from one systrapsync word, never both
   a_sys_trap_excl: assert property (@(posedge clk) disable iff (reset_i)
      dec_valid_o && (except_syscall_o || except_trap_o) |->
         !(except_syscall_o && except_trap_o) &&
         ($past(insn_i[31:26]) == opc_systrapsync))
      else $error("syscall or trap flagged wrongly");

endmodule

bind or1k_decode_top or1k_decode_asserts asserts0 (.*);

// File: or1k_decode_top.sv
//=============================
// Registered OR1K decode stage. A word taken on
// insn_valid_i is decoded and presented one
// cycle later with dec_valid_o
//=============================
`timescale 1ns/10ps

module or1k_decode_top import or1k_decode_pkg::*; (
   input  logic                     clk,
   input  logic                     reset_i,
   input  logic                     insn_valid_i,
   input  logic [insn_width-1:0]    insn_i,
   output logic                     dec_valid_o,
   output logic                     op_load_o, op_store_o, op_atomic_o, op_jbr_o,
                                    op_jr_o, op_jal_o, op_brcond_o, op_branch_o,
                                    op_alu_o, op_setflag_o, op_mfspr_o, op_mtspr_o,
                                    op_rfe_o, op_movhi_o, op_msync_o, op_add_o,
                                    op_mul_o, op_div_o, op_shift_o, rf_wb_o,
   output logic [1:0]               lsu_length_o,
   output logic                     lsu_zext_o,
   output logic [15:0]              imm16_o,
   output logic [insn_width-1:0]    immediate_o,
   output logic                     immediate_sel_o,
   output logic [9:0]               immjbr_upper_o,
   output logic [rf_addr_width-1:0] rfd_adr_o, rfa_adr_o, rfb_adr_o,
   output logic [alu_opc_width-1:0] opc_alu_o, opc_alu_secondary_o,
   output logic                     adder_do_sub_o, adder_do_carry_o,
   output logic                     except_illegal_o, except_syscall_o, except_trap_o
);

   or1k_insn_u insn;
   logic d_op_load, d_op_store, d_op_atomic, d_op_jbr, d_op_jr, d_op_jal;
   logic d_op_brcond, d_op_branch, d_op_alu, d_op_setflag, d_op_mfspr, d_op_mtspr;
   logic d_op_rfe, d_op_movhi, d_op_msync, d_op_add, d_op_mul, d_op_div, d_op_shift;
   logic d_rf_wb, d_lsu_zext, d_imm_sel, d_illegal, d_syscall, d_trap, d_sub, d_carry;
   logic [1:0]               d_lsu_length;
   logic [15:0]              d_imm16;
   logic [insn_width-1:0]    d_immediate;
   logic [9:0]               d_immjbr_upper;
   logic [rf_addr_width-1:0] d_rfd, d_rfa, d_rfb;
   logic [alu_opc_width-1:0] d_opc_alu, d_opc_alu_sec;
   // Flags cleared by reset
   logic [23:0]              ctl_d, ctl_q;

   assign insn = or1k_insn_u'(insn_i);

   or1k_decode_class class0 (
      .insn_i(insn), .op_load_o(d_op_load), .op_store_o(d_op_store),
      .op_atomic_o(d_op_atomic), .lsu_length_o(d_lsu_length), .lsu_zext_o(d_lsu_zext),
      .op_jbr_o(d_op_jbr), .op_jr_o(d_op_jr), .op_jal_o(d_op_jal),
      .op_brcond_o(d_op_brcond), .op_branch_o(d_op_branch), .op_alu_o(d_op_alu),
      .op_setflag_o(d_op_setflag), .op_mfspr_o(d_op_mfspr), .op_mtspr_o(d_op_mtspr),
      .op_rfe_o(d_op_rfe), .op_movhi_o(d_op_movhi), .op_msync_o(d_op_msync),
      .op_add_o(d_op_add), .op_mul_o(d_op_mul), .op_div_o(d_op_div),
      .op_shift_o(d_op_shift), .rf_wb_o(d_rf_wb));

   or1k_decode_imm imm0 (
      .insn_i(insn), .op_jal_i(d_op_jal), .op_store_i(d_op_store),
      .op_mtspr_i(d_op_mtspr), .op_movhi_i(d_op_movhi), .imm16_o(d_imm16),
      .immediate_o(d_immediate), .immediate_sel_o(d_imm_sel),
      .immjbr_upper_o(d_immjbr_upper), .rfd_adr_o(d_rfd), .rfa_adr_o(d_rfa),
      .rfb_adr_o(d_rfb));

   or1k_decode_alu alu0 (
      .insn_i(insn), .op_setflag_i(d_op_setflag), .opc_alu_o(d_opc_alu),
      .opc_alu_secondary_o(d_opc_alu_sec), .adder_do_sub_o(d_sub),
      .adder_do_carry_o(d_carry));

   or1k_decode_illegal illegal0 (
      .insn_i(insn), .except_illegal_o(d_illegal), .except_syscall_o(d_syscall),
      .except_trap_o(d_trap));

   assign ctl_d = {d_op_load, d_op_store, d_op_atomic, d_op_jbr, d_op_jr, d_op_jal,
                   d_op_brcond, d_op_branch, d_op_alu, d_op_setflag, d_op_mfspr,
                   d_op_mtspr, d_op_rfe, d_op_movhi, d_op_msync, d_op_add, d_op_mul,
                   d_op_div, d_op_shift, d_rf_wb, d_imm_sel, d_illegal, d_syscall, d_trap};

   assign {op_load_o, op_store_o, op_atomic_o, op_jbr_o, op_jr_o, op_jal_o,
           op_brcond_o, op_branch_o, op_alu_o, op_setflag_o, op_mfspr_o,
           op_mtspr_o, op_rfe_o, op_movhi_o, op_msync_o, op_add_o, op_mul_o,
           op_div_o, op_shift_o, rf_wb_o, immediate_sel_o, except_illegal_o,
           except_syscall_o, except_trap_o} = ctl_q;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         dec_valid_o <= 1'b0;
         ctl_q       <= '0;
      end else begin
         dec_valid_o <= insn_valid_i;
         if (insn_valid_i) begin
            ctl_q <= ctl_d;
         end
      end
   end

   // Decoded fields hold until the next strobe
   always_ff @(posedge clk) begin
      if (insn_valid_i) begin
         lsu_length_o        <= d_lsu_length;
         lsu_zext_o          <= d_lsu_zext;
         imm16_o             <= d_imm16;
         immediate_o         <= d_immediate;
         immjbr_upper_o      <= d_immjbr_upper;
         rfd_adr_o           <= d_rfd;
         rfa_adr_o           <= d_rfa;
         rfb_adr_o           <= d_rfb;
         opc_alu_o           <= d_opc_alu;
         opc_alu_secondary_o <= d_opc_alu_sec;
         adder_do_sub_o      <= d_sub;
         adder_do_carry_o    <= d_carry;
      end
   end

endmodule

// File: or1k_decode_illegal.sv
//=============================
// Illegal instruction, syscall and trap decode.
// Disabled features decode as illegal
//=============================
`timescale 1ns/10ps

module or1k_decode_illegal import or1k_decode_pkg::*; (
   input  or1k_insn_u insn_i,
   output logic       except_illegal_o,
   output logic       except_syscall_o,
   output logic       except_trap_o
);

   logic [opcode_width-1:0] opc;
   logic                    is_systrap;
   logic                    is_msync;
   logic                    shift_illegal;

   assign opc        = insn_i.rtype.opcode;
   assign is_systrap = (opc == opc_systrapsync);
   assign is_msync   = is_systrap && (insn_i.rtype.rd == sys_msync);

   assign except_syscall_o = is_systrap && (insn_i.rtype.rd == sys_syscall) && feat_syscall;
   assign except_trap_o    = is_systrap && (insn_i.rtype.rd == sys_trap) && feat_trap;

   // Shift type check for both l.shrti and register shifts
   always_comb begin
      case (insn_i.rtype.secondary)
         shrt_sll, shrt_srl: shift_illegal = 1'b0;
         shrt_sra:           shift_illegal = !feat_sra;
         shrt_ror:           shift_illegal = !feat_ror;
      endcase
   end

   always_comb begin
      case (opc)
         opc_j, opc_jal, opc_bnf, opc_bf, opc_nop, opc_movhi, opc_rfe, opc_jr:
            except_illegal_o = 1'b0;
         // jalr must not jump through the register it links into
         opc_jalr:
            except_illegal_o = (insn_i.rtype.rb == link_reg);
         opc_lwz, opc_lws, opc_lbz, opc_lbs, opc_lhz, opc_lhs, opc_addi, opc_andi,
         opc_ori, opc_xori, opc_mfspr, opc_sfimm, opc_mtspr, opc_sw, opc_sb, opc_sh,
         opc_sf:
            except_illegal_o = 1'b0;
         opc_lwa, opc_swa: except_illegal_o = !feat_atomic;
         opc_addic:        except_illegal_o = !feat_addc;
         opc_muli:         except_illegal_o = !feat_mul;
         opc_shrti:        except_illegal_o = shift_illegal;
         opc_alu: begin
            case (insn_i.rtype.alu_opc)
               alu_add, alu_sub, alu_and, alu_or, alu_xor: except_illegal_o = 1'b0;
               alu_addc:            except_illegal_o = !feat_addc;
               alu_mul, alu_mulu:   except_illegal_o = !feat_mul;
               alu_div, alu_divu:   except_illegal_o = !feat_div;
               alu_shrt:            except_illegal_o = shift_illegal;
               alu_extbh, alu_extw: except_illegal_o = !feat_ext;
               alu_cmov:            except_illegal_o = !feat_cmov;
               alu_ffl1:            except_illegal_o = !feat_ffl1;
               default:             except_illegal_o = 1'b1;
            endcase
         end
         opc_systrapsync:
            except_illegal_o = !(except_syscall_o || except_trap_o || is_msync);
         // Custom, FPU, MAC and 64-bit opcodes land here too
         default:
            except_illegal_o = 1'b1;
      endcase
   end

endmodule

// File: or1k_decode_alu.sv
//=============================
// ALU opcode mapping and adder controls
//=============================
`timescale 1ns/10ps

module or1k_decode_alu import or1k_decode_pkg::*; (
   input  or1k_insn_u               insn_i,
   input  logic                     op_setflag_i,
   output logic [alu_opc_width-1:0] opc_alu_o,
   output logic [alu_opc_width-1:0] opc_alu_secondary_o,
   output logic                     adder_do_sub_o,
   output logic                     adder_do_carry_o
);

   logic [opcode_width-1:0] opc;

   assign opc = insn_i.rtype.opcode;

   // Logic immediates carry no function field of their own
   always_comb begin
      case (opc)
         opc_ori:  opc_alu_o = alu_or;
         opc_andi: opc_alu_o = alu_and;
         opc_xori: opc_alu_o = alu_xor;
         default:  opc_alu_o = insn_i.rtype.alu_opc;
      endcase
   end

   // Compare condition sits in bits 24:21
   assign opc_alu_secondary_o = op_setflag_i ? insn_i.rtype.rd[3:0] :
                                               {2'b00, insn_i.rtype.secondary};

   assign adder_do_sub_o   = ((opc == opc_alu) && (insn_i.rtype.alu_opc == alu_sub)) ||
                             op_setflag_i;
   assign adder_do_carry_o = feat_addc &&
                             (((opc == opc_alu) && (insn_i.rtype.alu_opc == alu_addc)) ||
                              (opc == opc_addic));

endmodule

// File: or1k_decode_imm.sv
//=============================
// Immediate extraction and GPR addresses.
// Takes the class flags from the class decoder
//=============================
`timescale 1ns/10ps

module or1k_decode_imm import or1k_decode_pkg::*; (
   input  or1k_insn_u               insn_i,
   input  logic                     op_jal_i,
   input  logic                     op_store_i,
   input  logic                     op_mtspr_i,
   input  logic                     op_movhi_i,
   output logic [15:0]              imm16_o,
   output logic [insn_width-1:0]    immediate_o,
   output logic                     immediate_sel_o,
   output logic [9:0]               immjbr_upper_o,
   output logic [rf_addr_width-1:0] rfd_adr_o, rfa_adr_o, rfb_adr_o
);

   logic [opcode_width-1:0] opc;
   logic                    sext_sel;
   logic                    zext_sel;

   assign opc = insn_i.itype.opcode;

   // Stores and mtspr split the immediate around rb
   assign imm16_o = (op_store_i || op_mtspr_i) ? {insn_i.rtype.rd, insn_i[10:0]} :
                                                 insn_i.itype.imm16;
   assign immjbr_upper_o = insn_i[25:16];

   assign sext_sel = ((opc[5:4] == 2'b10) && (opc != opc_ori) && (opc != opc_andi)) ||
                     op_store_i || (opc == opc_lwa);
   assign zext_sel = (opc == opc_ori) || (opc == opc_andi) || op_mtspr_i;

   // Sign extend wins, then zero extend, then the movhi form
   assign immediate_o = sext_sel ? {{16{imm16_o[15]}}, imm16_o} :
                        zext_sel ? {16'h0000, imm16_o} : {imm16_o, 16'h0000};
   assign immediate_sel_o = sext_sel || zext_sel || op_movhi_i;

   assign rfd_adr_o = op_jal_i ? link_reg : insn_i.rtype.rd;
   assign rfa_adr_o = insn_i.rtype.ra;
   assign rfb_adr_o = insn_i.rtype.rb;

endmodule

// File: or1k_decode_class.sv
//=============================
// Operation class decode. Flags the kind of
// instruction, LSU length and writeback
//=============================
`timescale 1ns/10ps

module or1k_decode_class import or1k_decode_pkg::*; (
   input  or1k_insn_u insn_i,
   output logic       op_load_o, op_store_o, op_atomic_o,
   output logic [1:0] lsu_length_o,
   output logic       lsu_zext_o,
   output logic       op_jbr_o, op_jr_o, op_jal_o, op_brcond_o, op_branch_o,
   output logic       op_alu_o, op_setflag_o, op_mfspr_o, op_mtspr_o,
   output logic       op_rfe_o, op_movhi_o, op_msync_o,
   output logic       op_add_o, op_mul_o, op_div_o, op_shift_o,
   output logic       rf_wb_o
);

   logic [opcode_width-1:0]  opc;
   logic [alu_opc_width-1:0] alu_fn;
   logic                     is_alu;

   assign opc    = insn_i.rtype.opcode;
   assign alu_fn = insn_i.rtype.alu_opc;
   assign is_alu = (opc == opc_alu);

   // Loads sit at 10_0000 to 10_0110, lwa elsewhere
   assign op_load_o   = ((opc[5:4] == 2'b10) && (opc[3:0] < 4'h7)) ||
                        ((opc == opc_lwa) && feat_atomic);
   assign op_store_o  = (opc == opc_sw) || (opc == opc_sb) || (opc == opc_sh) ||
                        ((opc == opc_swa) && feat_atomic);
   assign op_atomic_o = ((opc == opc_lwa) || (opc == opc_swa)) && feat_atomic;
   assign lsu_zext_o  = opc[0];

   always_comb begin
      case (opc)
         opc_sb, opc_lbz, opc_lbs: lsu_length_o = 2'b00;
         opc_sh, opc_lhz, opc_lhs: lsu_length_o = 2'b01;
         default:                  lsu_length_o = 2'b10;
      endcase
   end

   // Opcodes below l.nop jump or branch on an immediate
   assign op_jbr_o    = (opc < opc_nop);
   assign op_jr_o     = (opc == opc_jr) || (opc == opc_jalr);
   assign op_jal_o    = (opc == opc_jal) || (opc == opc_jalr);
   assign op_brcond_o = (opc == opc_bf) || (opc == opc_bnf);
   assign op_branch_o = op_jbr_o || op_jr_o || op_jal_o;

   assign op_alu_o     = is_alu || (opc == opc_ori) || (opc == opc_andi) ||
                         (opc == opc_xori);
   assign op_setflag_o = (opc == opc_sf) || (opc == opc_sfimm);
   assign op_mfspr_o   = (opc == opc_mfspr);
   assign op_mtspr_o   = (opc == opc_mtspr);
   assign op_rfe_o     = (opc == opc_rfe);
   assign op_movhi_o   = (opc == opc_movhi);
   assign op_msync_o   = (opc == opc_systrapsync) && (insn_i.rtype.rd == sys_msync);

   assign op_add_o   = (is_alu && ((alu_fn == alu_add) || (alu_fn == alu_addc) ||
                                   (alu_fn == alu_sub))) ||
                       (opc == opc_addi) || (opc == opc_addic);
   assign op_mul_o   = (is_alu && ((alu_fn == alu_mul) || (alu_fn == alu_mulu))) ||
                       (opc == opc_muli);
   assign op_div_o   = is_alu && ((alu_fn == alu_div) || (alu_fn == alu_divu));
   assign op_shift_o = (is_alu && (alu_fn == alu_shrt)) || (opc == opc_shrti);

   // Writeback for links, movhi, lwa, 10xxxx except sfimm,
   // and 11xxxx except compares, mtspr and stores
   assign rf_wb_o = op_jal_o || op_movhi_o || (opc == opc_lwa) ||
                    ((opc[5:4] == 2'b10) && (opc != opc_sfimm)) ||
                    ((opc[5:4] == 2'b11) && !((opc == opc_sf) || op_mtspr_o || op_store_o));

endmodule

// File: or1k_decode_pkg.sv
//=============================
// Shared constants for the OR1K decode stage:
// opcodes, ALU functions, feature enables and
// the instruction word union. Modules pull it in
// with a wildcard import in their header
//=============================
package or1k_decode_pkg;

   localparam int insn_width    = 32;
   localparam int rf_addr_width = 5;
   localparam int alu_opc_width = 4;
   localparam int opcode_width  = 6;

   // Link register written by l.jal and l.jalr
   localparam logic [rf_addr_width-1:0] link_reg = 5'd9;

   // Major opcodes, bits 31:26
   localparam logic [opcode_width-1:0]
      opc_j     = 6'h00, opc_jal   = 6'h01, opc_bnf   = 6'h03,
      opc_bf    = 6'h04, opc_nop   = 6'h05, opc_movhi = 6'h06,
      opc_rfe   = 6'h09, opc_jr    = 6'h11, opc_jalr  = 6'h12,
      opc_lwa   = 6'h1b, opc_lwz   = 6'h21, opc_lws   = 6'h22,
      opc_lbz   = 6'h23, opc_lbs   = 6'h24, opc_lhz   = 6'h25,
      opc_lhs   = 6'h26, opc_addi  = 6'h27, opc_addic = 6'h28,
      opc_andi  = 6'h29, opc_ori   = 6'h2a, opc_xori  = 6'h2b,
      opc_muli  = 6'h2c, opc_mfspr = 6'h2d, opc_shrti = 6'h2e,
      opc_sfimm = 6'h2f, opc_mtspr = 6'h30, opc_swa   = 6'h33,
      opc_sw    = 6'h35, opc_sb    = 6'h36, opc_sh    = 6'h37,
      opc_alu   = 6'h38, opc_sf    = 6'h39;

   // Sys, trap and the sync family share this opcode
   localparam logic [opcode_width-1:0] opc_systrapsync = 6'h08;

   // Function field of the register form ALU opcode, bits 3:0
   localparam logic [alu_opc_width-1:0]
      alu_add   = 4'h0, alu_addc  = 4'h1, alu_sub  = 4'h2,
      alu_and   = 4'h3, alu_or    = 4'h4, alu_xor  = 4'h5,
      alu_mul   = 4'h6, alu_shrt  = 4'h8, alu_div  = 4'h9,
      alu_divu  = 4'ha, alu_mulu  = 4'hb, alu_extbh = 4'hc,
      alu_extw  = 4'hd, alu_cmov  = 4'he, alu_ffl1 = 4'hf;

   // Shift type, bits 7:6
   localparam logic [1:0]
      shrt_sll = 2'd0, shrt_srl = 2'd1, shrt_sra = 2'd2, shrt_ror = 2'd3;

   // Sub-opcode of the systrapsync group, bits 25:21
   localparam logic [4:0]
      sys_syscall = 5'h00, sys_trap = 5'h08, sys_msync = 5'h10;

   // Optional instruction groups of this core
   localparam bit
      feat_atomic  = 1'b1, feat_mul  = 1'b1, feat_div  = 1'b0,
      feat_addc    = 1'b0, feat_sra  = 1'b1, feat_ror  = 1'b0,
      feat_cmov    = 1'b0, feat_ffl1 = 1'b0, feat_ext  = 1'b0,
      feat_syscall = 1'b1, feat_trap = 1'b1;

   // Register form and immediate form views of one word
   typedef union packed {
      struct packed {
         logic [opcode_width-1:0]  opcode;
         logic [rf_addr_width-1:0] rd;
         logic [rf_addr_width-1:0] ra;
         logic [rf_addr_width-1:0] rb;
         logic [2:0]               rsvd_hi;
         logic [1:0]               secondary;
         logic [1:0]               rsvd_lo;
         logic [alu_opc_width-1:0] alu_opc;
      } rtype;
      struct packed {
         logic [opcode_width-1:0]  opcode;
         logic [rf_addr_width-1:0] rd;
         logic [rf_addr_width-1:0] ra;
         logic [15:0]              imm16;
      } itype;
   } or1k_insn_u;

endpackage
